//--- filelist.f
design/exec_pkg.sv
design/exec_if.sv
design/reservation_station.sv
design/fu_scheduler.sv
design/int_alu.sv
design/mul_unit.sv
design/div_unit.sv
design/result_arbiter.sv
design/exec_top.sv
tb/exec_properties.sv
tb/exec_tb.sv

//--- Bender.yml
package:
  name: exec_stage

sources:
  - design/exec_pkg.sv
  - design/exec_if.sv
  - design/reservation_station.sv
  - design/fu_scheduler.sv
  - design/int_alu.sv
  - design/mul_unit.sv
  - design/div_unit.sv
  - design/result_arbiter.sv
  - design/exec_top.sv
  - target: simulation
    files:
      - tb/exec_properties.sv
      - tb/exec_tb.sv

//--- tb/exec_tb.sv
// ############################
// Execute stage testbench
// Directed and random tests checked against a tag scoreboard
// ############################

`timescale 1ns/1ps

module exec_tb;

    localparam int NUM_INSTR      = 68;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 40 + 200;

    logic               clk;
    logic               rst_n;
    logic               in_valid;
    logic               in_ready;
    exec_pkg::alu_op_t  in_op;
    exec_pkg::rob_tag_t in_rob;
    exec_pkg::word_t    in_src_a;
    exec_pkg::word_t    in_src_b;
    logic               result_valid;
    exec_pkg::rob_tag_t result_rob;
    exec_pkg::word_t    result_value;

    // One expected value and one outstanding flag per tag
    exec_pkg::word_t    exp_value [16];
    logic [15:0]        pending;
    logic               saw_full;
    logic [31:0]        rand_state;
    int                 cycle_count;

    exec_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_op        (in_op),
        .in_rob       (in_rob),
        .in_src_a     (in_src_a),
        .in_src_b     (in_src_b),
        .result_valid (result_valid),
        .result_rob   (result_rob),
        .result_value (result_value)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] next_rand();
        rand_state = rand_state ^ (rand_state << 13);
        rand_state = rand_state ^ (rand_state >> 17);
        rand_state = rand_state ^ (rand_state << 5);
        return rand_state;
    endfunction

    function automatic exec_pkg::word_t expected_result(exec_pkg::alu_op_t op,
                                                        exec_pkg::word_t a,
                                                        exec_pkg::word_t b);
        logic [63:0] prod;
        logic [4:0]  sh;
        prod = {32'b0, a} * {32'b0, b};
        sh   = b[4:0];
        case (op)
            exec_pkg::ADD:   return a + b;
            exec_pkg::SUB:   return a - b;
            exec_pkg::AND:   return a & b;
            exec_pkg::OR:    return a | b;
            exec_pkg::XOR:   return a ^ b;
            // Differing signs decide on the sign of a alone
            exec_pkg::SLT:   return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            exec_pkg::SLL:   return a << sh;
            exec_pkg::SRL:   return a >> sh;
            exec_pkg::SRA:   return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            exec_pkg::MUL:   return prod[31:0];
            exec_pkg::MULHU: return prod[63:32];
            exec_pkg::DIVU:  return (b == 0) ? 32'hffff_ffff : a / b;
            exec_pkg::REMU:  return (b == 0) ? a : a % b;
            default:         return 32'h0;
        endcase
    endfunction

    // Leaves in_valid high so the next send can follow without a bubble
    task automatic send(input exec_pkg::alu_op_t op, input exec_pkg::rob_tag_t rob,
                        input exec_pkg::word_t a, input exec_pkg::word_t b);
        logic accepted;
        if (pending[rob]) begin
            in_valid <= 1'b0;
            while (pending[rob]) @(posedge clk);
        end
        exp_value[rob] = expected_result(op, a, b);
        pending[rob]   = 1'b1;
        in_valid <= 1'b1;
        in_op    <= op;
        in_rob   <= rob;
        in_src_a <= a;
        in_src_b <= b;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = in_ready;
            if (!accepted) saw_full = 1'b1;
            @(posedge clk);
        end
    endtask

    task automatic drain();
        in_valid <= 1'b0;
        while (pending != '0) @(posedge clk);
    endtask

    task automatic check_reset();
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            if (i == 3) rst_n <= 1'b1;
            @(negedge clk);
            check_value("result_valid", result_valid, 32'h0);
            check_value("in_ready", in_ready, 32'h1);
        end
        @(posedge clk);
        @(negedge clk);
        check_value("result_valid", result_valid, 32'h0);
        check_value("in_ready", in_ready, 32'h1);
        @(posedge clk);
    endtask

    task automatic test_alu_ops();
        send(exec_pkg::ADD, 4'd0, 32'h7fff_ffff, 32'h0000_0003);
        send(exec_pkg::SUB, 4'd1, 32'h0000_0003, 32'h0000_000a);
        send(exec_pkg::AND, 4'd2, 32'hf0f0_1234, 32'h0ff0_ff00);
        send(exec_pkg::OR,  4'd3, 32'hf000_0001, 32'h0000_8010);
        send(exec_pkg::XOR, 4'd4, 32'haaaa_5555, 32'hffff_0000);
        send(exec_pkg::SLT, 4'd5, 32'hffff_fffe, 32'h0000_0001);
        send(exec_pkg::SLL, 4'd6, 32'h8000_0003, 32'h0000_0024);
        send(exec_pkg::SRL, 4'd7, 32'h8000_0000, 32'h0000_001f);
        send(exec_pkg::SRA, 4'd8, 32'h8000_0f00, 32'h0000_0008);
        drain();
        // The product wins the result bus over the held ADD, so the XOR goes to ALU1
        send(exec_pkg::MUL, 4'd9,  32'h0001_0001, 32'h0000_0123);
        send(exec_pkg::ADD, 4'd10, 32'h0000_1000, 32'h0000_0234);
        send(exec_pkg::XOR, 4'd11, 32'h1234_5678, 32'h8765_4321);
        drain();
    endtask

    task automatic test_multiply();
        send(exec_pkg::MUL,   4'd0, 32'hffff_ffff, 32'hffff_ffff);
        send(exec_pkg::MULHU, 4'd1, 32'hffff_ffff, 32'hffff_ffff);
        send(exec_pkg::MUL,   4'd2, 32'hdead_beef, 32'h1234_5678);
        send(exec_pkg::MULHU, 4'd3, 32'hdead_beef, 32'h1234_5678);
        drain();
    endtask

    task automatic test_divide();
        send(exec_pkg::DIVU, 4'd0, 32'd100, 32'd7);
        send(exec_pkg::REMU, 4'd1, 32'd100, 32'd7);
        send(exec_pkg::DIVU, 4'd2, 32'hffff_ffff, 32'h0001_0003);
        send(exec_pkg::REMU, 4'd3, 32'hffff_ffff, 32'h0001_0003);
        send(exec_pkg::DIVU, 4'd4, 32'h0000_1234, 32'h0);
        send(exec_pkg::REMU, 4'd5, 32'h0000_1234, 32'h0);
        drain();
    endtask

    // The busy divider holds the rest back until the station fills
    task automatic test_div_backpressure();
        saw_full = 1'b0;
        for (int i = 0; i < 6; i++) begin
            send((i % 2 == 0) ? exec_pkg::DIVU : exec_pkg::REMU, 4'(i + 6),
                 next_rand(), next_rand() >> (i * 5));
        end
        drain();
        if (!saw_full) abort_run("in_ready never went low while the divider was busy");
    endtask

    task automatic test_random_mix();
        exec_pkg::alu_op_t op;
        exec_pkg::word_t   a;
        exec_pkg::word_t   b;
        for (int i = 0; i < 40; i++) begin
            op = exec_pkg::alu_op_t'(4'(1 + next_rand() % 13));
            a  = next_rand();
            b  = next_rand() >> a[4:0];
            send(op, 4'(i % 16), a, b);
        end
        drain();
    endtask

    always @(negedge clk) begin
        if (rst_n && result_valid) begin
            if (!pending[result_rob]) begin
                abort_run($sformatf("Result came back for tag %0d, which was not outstanding",
                                    result_rob));
            end else begin
                check_value($sformatf("result_value (tag %0d)", result_rob), result_value,
                            exp_value[result_rob]);
                pending[result_rob] = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout after %0d cycles with tags still outstanding",
                                cycle_count));
        end
    end

    initial begin
        rand_state  = 32'd4875;
        pending     = '0;
        saw_full    = 1'b0;
        cycle_count = 0;
        clk         = 1'b0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_op       = exec_pkg::NOP;
        in_rob      = '0;
        in_src_a    = '0;
        in_src_b    = '0;
        check_reset();
        test_alu_ops();
        test_multiply();
        test_divide();
        test_div_backpressure();
        test_random_mix();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- tb/exec_properties.sv
// ############################
// Execute stage assertions
// Handshake and arbiter rules on the top level
// ############################

`timescale 1ns/1ps

module exec_properties (
    input logic                                  clk,
    input logic                                  rst_n,
    input logic                                  in_ready,
    input logic                                  result_valid,
    input logic [exec_pkg::RS_DEPTH-1:0]         entry_valid,
    input logic [exec_pkg::NUM_UNITS-1:0]        req,
    input logic [exec_pkg::NUM_UNITS-1:0]        grant,
    input logic [4*exec_pkg::NUM_UNITS-1:0]      rob_all,
    input logic [32*exec_pkg::NUM_UNITS-1:0]     value_all
);

    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant))
        else $error("arbiter granted more than one unit");

    assert property (@(posedge clk) !rst_n |=> !result_valid)
        else $error("result_valid high right after reset");

    assert property (@(posedge clk) disable iff (!rst_n) (&entry_valid) |-> !in_ready)
        else $error("in_ready high with every station entry valid");

    // Unit order is ALU0, ALU1, MUL, DIV from bit 0 up
    for (genvar u = 0; u < exec_pkg::NUM_UNITS; u++) begin : g_hold
        assert property (@(posedge clk) disable iff (!rst_n)
            req[u] && !grant[u] |=> req[u] && $stable(rob_all[4*u +: 4])
                                   && $stable(value_all[32*u +: 32]))
            else $error("unit %0d changed a held result before grant", u);
    end

endmodule

bind exec_top exec_properties u_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_ready     (in_ready),
    .result_valid (result_valid),
    .entry_valid  (entry_valid),
    .req          ({div_res.req, mul_res.req, alu1_res.req, alu0_res.req}),
    .grant        ({div_res.grant, mul_res.grant, alu1_res.grant, alu0_res.grant}),
    .rob_all      ({div_res.rob, mul_res.rob, alu1_res.rob, alu0_res.rob}),
    .value_all    ({div_res.value, mul_res.value, alu1_res.value, alu0_res.value})
);

//--- design/exec_top.sv
// ############################
// Execute stage top level
// Station, scheduler, four units and result arbiter
// ############################

`timescale 1ns/1ps

module exec_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    output logic               in_ready,
    input  exec_pkg::alu_op_t  in_op,
    input  exec_pkg::rob_tag_t in_rob,
    input  exec_pkg::word_t    in_src_a,
    input  exec_pkg::word_t    in_src_b,
    output logic               result_valid,
    output exec_pkg::rob_tag_t result_rob,
    output exec_pkg::word_t    result_value
);

    logic [exec_pkg::RS_DEPTH-1:0] issue_take;
    logic [exec_pkg::RS_DEPTH-1:0] entry_valid;
    exec_pkg::alu_op_t             entry_op    [exec_pkg::RS_DEPTH];
    exec_pkg::rob_tag_t            entry_rob   [exec_pkg::RS_DEPTH];
    exec_pkg::word_t               entry_src_a [exec_pkg::RS_DEPTH];
    exec_pkg::word_t               entry_src_b [exec_pkg::RS_DEPTH];

    issue_if  alu0_iss ();
    issue_if  alu1_iss ();
    issue_if  mul_iss ();
    issue_if  div_iss ();
    result_if alu0_res ();
    result_if alu1_res ();
    result_if mul_res ();
    result_if div_res ();

    reservation_station u_rs (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_op       (in_op),
        .in_rob      (in_rob),
        .in_src_a    (in_src_a),
        .in_src_b    (in_src_b),
        .issue_take  (issue_take),
        .entry_valid (entry_valid),
        .entry_op    (entry_op),
        .entry_rob   (entry_rob),
        .entry_src_a (entry_src_a),
        .entry_src_b (entry_src_b)
    );

    fu_scheduler u_sched (
        .entry_valid (entry_valid),
        .entry_op    (entry_op),
        .entry_rob   (entry_rob),
        .entry_src_a (entry_src_a),
        .entry_src_b (entry_src_b),
        .issue_take  (issue_take),
        .alu0        (alu0_iss.sched),
        .alu1        (alu1_iss.sched),
        .mul         (mul_iss.sched),
        .div         (div_iss.sched)
    );

    int_alu  u_alu0 (.clk(clk), .rst_n(rst_n), .iss(alu0_iss.unit), .res(alu0_res.unit));
    int_alu  u_alu1 (.clk(clk), .rst_n(rst_n), .iss(alu1_iss.unit), .res(alu1_res.unit));
    mul_unit u_mul  (.clk(clk), .rst_n(rst_n), .iss(mul_iss.unit),  .res(mul_res.unit));
    div_unit u_div  (.clk(clk), .rst_n(rst_n), .iss(div_iss.unit),  .res(div_res.unit));

    result_arbiter u_arb (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_alu0     (alu0_res.arb),
        .req_alu1     (alu1_res.arb),
        .req_mul      (mul_res.arb),
        .req_div      (div_res.arb),
        .result_valid (result_valid),
        .result_rob   (result_rob),
        .result_value (result_value)
    );

endmodule

//--- design/result_arbiter.sv
// ############################
// Result arbiter
// Round-robin grant of one unit result onto the result bus
// ############################

`timescale 1ns/1ps

module result_arbiter (
    input  logic               clk,
    input  logic               rst_n,
    result_if.arb              req_alu0,
    result_if.arb              req_alu1,
    result_if.arb              req_mul,
    result_if.arb              req_div,
    output logic               result_valid,
    output exec_pkg::rob_tag_t result_rob,
    output exec_pkg::word_t    result_value
);

    exec_pkg::unit_sel_t                     reqs;
    exec_pkg::unit_sel_t                     grant;
    logic [$clog2(exec_pkg::NUM_UNITS)-1:0]  last;
    logic [$clog2(exec_pkg::NUM_UNITS)-1:0]  idx;
    logic [$clog2(exec_pkg::NUM_UNITS)-1:0]  win;
    exec_pkg::rob_tag_t                      robs [exec_pkg::NUM_UNITS];
    exec_pkg::word_t                         vals [exec_pkg::NUM_UNITS];

    assign reqs = {req_div.req, req_mul.req, req_alu1.req, req_alu0.req};
    assign robs = '{req_alu0.rob, req_alu1.rob, req_mul.rob, req_div.rob};
    assign vals = '{req_alu0.value, req_alu1.value, req_mul.value, req_div.value};

    // Search starts one past the unit granted last
    always_comb begin
        grant = '0;
        win   = last;
        idx   = last;
        for (int k = 0; k < exec_pkg::NUM_UNITS; k++) begin
            idx = idx + 1'b1;
            if (reqs[idx] && grant == '0) begin
                grant[idx] = 1'b1;
                win        = idx;
            end
        end
    end

    assign req_alu0.grant = grant[0];
    assign req_alu1.grant = grant[1];
    assign req_mul.grant  = grant[2];
    assign req_div.grant  = grant[3];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            last         <= '1;
        end else begin
            result_valid <= |grant;
            if (|grant) begin
                last <= win;
            end
        end
    end

    always_ff @(posedge clk) begin
        result_rob   <= robs[win];
        result_value <= vals[win];
    end

endmodule

//--- design/div_unit.sv
// ############################
// Iterative divider
// Restoring unsigned divide, one quotient bit per cycle
// ############################

`timescale 1ns/1ps

module div_unit (
    input logic     clk,
    input logic     rst_n,
    issue_if.unit   iss,
    result_if.unit  res
);

    typedef enum logic [1:0] {IDLE, RUN, DONE} div_state_t;

    div_state_t                                state;
    logic                                      fire;
    logic                                      is_rem;
    logic [$clog2(exec_pkg::DIV_STEPS)-1:0]    cnt;
    exec_pkg::rob_tag_t                        rob_q;
    exec_pkg::word_t                           quo;
    exec_pkg::word_t                           rem;
    exec_pkg::word_t                           divisor;
    logic [32:0]                               shifted;
    logic [32:0]                               diff;

    // A zero divisor never borrows, leaving all ones and the dividend
    assign shifted = {rem, quo[31]};
    assign diff    = shifted - {1'b0, divisor};

    assign iss.ready = (state == IDLE) || (state == DONE && res.grant);
    assign fire      = iss.valid && iss.ready;

    assign res.req   = (state == DONE);
    assign res.rob   = rob_q;
    assign res.value = is_rem ? rem : quo;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (fire) state <= RUN;
                RUN:  if (int'(cnt) == exec_pkg::DIV_STEPS - 1) state <= DONE;
                DONE: begin
                    if (fire) begin
                        state <= RUN;
                    end else if (res.grant) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            quo     <= iss.src_a;
            rem     <= '0;
            divisor <= iss.src_b;
            cnt     <= '0;
            is_rem  <= (iss.op == exec_pkg::REMU);
            rob_q   <= iss.rob;
        end else if (state == RUN) begin
            quo <= {quo[30:0], !diff[32]};
            rem <= diff[32] ? shifted[31:0] : diff[31:0];
            cnt <= cnt + 1'b1;
        end
    end

endmodule

//--- design/mul_unit.sv
// ############################
// Pipelined multiplier
// Two-stage unsigned multiply returning low or high word
// ############################

`timescale 1ns/1ps

module mul_unit (
    input logic     clk,
    input logic     rst_n,
    issue_if.unit   iss,
    result_if.unit  res
);

    logic               advance;
    logic               fire;
    logic               s1_valid;
    logic               s1_high;
    exec_pkg::rob_tag_t s1_rob;
    logic [63:0]        s1_prod;

    // Whole pipeline freezes behind an ungranted output
    assign advance   = !res.req || res.grant;
    assign iss.ready = advance;
    assign fire      = iss.valid && advance;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            res.req  <= 1'b0;
        end else if (advance) begin
            s1_valid <= fire;
            res.req  <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            s1_prod   <= 64'(iss.src_a) * 64'(iss.src_b);
            s1_high   <= (iss.op == exec_pkg::MULHU);
            s1_rob    <= iss.rob;
            res.rob   <= s1_rob;
            res.value <= s1_high ? s1_prod[63:32] : s1_prod[31:0];
        end
    end

endmodule

//--- design/int_alu.sv
// ############################
// Integer ALU
// Single-cycle arithmetic, logic and shift with held result
// ############################

`timescale 1ns/1ps

module int_alu (
    input logic     clk,
    input logic     rst_n,
    issue_if.unit   iss,
    result_if.unit  res
);

    exec_pkg::word_t result;
    logic            fire;

    always_comb begin
        case (iss.op)
            exec_pkg::ADD: result = iss.src_a + iss.src_b;
            exec_pkg::SUB: result = iss.src_a - iss.src_b;
            exec_pkg::AND: result = iss.src_a & iss.src_b;
            exec_pkg::OR:  result = iss.src_a | iss.src_b;
            exec_pkg::XOR: result = iss.src_a ^ iss.src_b;
            exec_pkg::SLT: result = {31'b0, $signed(iss.src_a) < $signed(iss.src_b)};
            exec_pkg::SLL: result = iss.src_a << iss.src_b[4:0];
            exec_pkg::SRL: result = iss.src_a >> iss.src_b[4:0];
            exec_pkg::SRA: result = exec_pkg::word_t'($signed(iss.src_a) >>> iss.src_b[4:0]);
            default:       result = '0;
        endcase
    end

    // Free again once the held result is taken by the arbiter
    assign iss.ready = !res.req || res.grant;
    assign fire      = iss.valid && iss.ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res.req <= 1'b0;
        end else if (fire) begin
            res.req <= 1'b1;
        end else if (res.grant) begin
            res.req <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            res.rob   <= iss.rob;
            res.value <= result;
        end
    end

endmodule

//--- design/fu_scheduler.sv
// ############################
// Functional unit scheduler
// Sends the lowest issuable entry to a free compatible unit
// ############################

`timescale 1ns/1ps

module fu_scheduler (
    input  logic [exec_pkg::RS_DEPTH-1:0] entry_valid,
    input  exec_pkg::alu_op_t             entry_op    [exec_pkg::RS_DEPTH],
    input  exec_pkg::rob_tag_t            entry_rob   [exec_pkg::RS_DEPTH],
    input  exec_pkg::word_t               entry_src_a [exec_pkg::RS_DEPTH],
    input  exec_pkg::word_t               entry_src_b [exec_pkg::RS_DEPTH],
    output logic [exec_pkg::RS_DEPTH-1:0] issue_take,
    issue_if.sched                        alu0,
    issue_if.sched                        alu1,
    issue_if.sched                        mul,
    issue_if.sched                        div
);

    exec_pkg::unit_sel_t           rdy;
    exec_pkg::unit_sel_t           sel;
    exec_pkg::unit_sel_t           cand;
    logic [exec_pkg::RS_DEPTH-1:0] take;
    logic                          fire;
    exec_pkg::alu_op_t             op_s;
    exec_pkg::rob_tag_t            rob_s;
    exec_pkg::word_t               src_a_s;
    exec_pkg::word_t               src_b_s;

    // ALU class operations prefer ALU0 and fall back to ALU1
    function automatic exec_pkg::unit_sel_t route(exec_pkg::alu_op_t op,
                                                  exec_pkg::unit_sel_t ready);
        route = '0;
        if (op inside {exec_pkg::MUL, exec_pkg::MULHU}) begin
            route[2] = ready[2];
        end else if (op inside {exec_pkg::DIVU, exec_pkg::REMU}) begin
            route[3] = ready[3];
        end else if (ready[0]) begin
            route[0] = 1'b1;
        end else begin
            route[1] = ready[1];
        end
    endfunction

    assign rdy = {div.ready, mul.ready, alu1.ready, alu0.ready};

    // A blocked entry does not hold back the entries above it
    always_comb begin
        sel     = '0;
        cand    = '0;
        take    = '0;
        op_s    = exec_pkg::NOP;
        rob_s   = '0;
        src_a_s = '0;
        src_b_s = '0;
        for (int i = 0; i < exec_pkg::RS_DEPTH; i++) begin
            cand = route(entry_op[i], rdy);
            if (entry_valid[i] && cand != '0 && sel == '0) begin
                sel     = cand;
                take[i] = 1'b1;
                op_s    = entry_op[i];
                rob_s   = entry_rob[i];
                src_a_s = entry_src_a[i];
                src_b_s = entry_src_b[i];
            end
        end
    end

    assign fire       = |(sel & rdy);
    assign issue_take = take & {exec_pkg::RS_DEPTH{fire}};

    assign alu0.valid = sel[0];
    assign alu0.op    = op_s;
    assign alu0.rob   = rob_s;
    assign alu0.src_a = src_a_s;
    assign alu0.src_b = src_b_s;

    assign alu1.valid = sel[1];
    assign alu1.op    = op_s;
    assign alu1.rob   = rob_s;
    assign alu1.src_a = src_a_s;
    assign alu1.src_b = src_b_s;

    assign mul.valid  = sel[2];
    assign mul.op     = op_s;
    assign mul.rob    = rob_s;
    assign mul.src_a  = src_a_s;
    assign mul.src_b  = src_b_s;

    assign div.valid  = sel[3];
    assign div.op     = op_s;
    assign div.rob    = rob_s;
    assign div.src_a  = src_a_s;
    assign div.src_b  = src_b_s;

endmodule

//--- design/reservation_station.sv
// ############################
// Reservation station
// Four entries of resolved instructions waiting for a unit
// ############################

`timescale 1ns/1ps

module reservation_station (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  exec_pkg::alu_op_t             in_op,
    input  exec_pkg::rob_tag_t            in_rob,
    input  exec_pkg::word_t               in_src_a,
    input  exec_pkg::word_t               in_src_b,
    input  logic [exec_pkg::RS_DEPTH-1:0] issue_take,
    output logic [exec_pkg::RS_DEPTH-1:0] entry_valid,
    output exec_pkg::alu_op_t             entry_op    [exec_pkg::RS_DEPTH],
    output exec_pkg::rob_tag_t            entry_rob   [exec_pkg::RS_DEPTH],
    output exec_pkg::word_t               entry_src_a [exec_pkg::RS_DEPTH],
    output exec_pkg::word_t               entry_src_b [exec_pkg::RS_DEPTH]
);

    logic [exec_pkg::RS_DEPTH-1:0] alloc;
    logic                          accept;

    assign in_ready = ~&entry_valid;
    assign accept   = in_valid && in_ready;

    // Entries freed this cycle still look busy, so they refill a cycle later
    always_comb begin
        alloc = '0;
        for (int i = 0; i < exec_pkg::RS_DEPTH; i++) begin
            if (!entry_valid[i] && alloc == '0) begin
                alloc[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else begin
            for (int i = 0; i < exec_pkg::RS_DEPTH; i++) begin
                if (issue_take[i]) begin
                    entry_valid[i] <= 1'b0;
                end else if (accept && alloc[i]) begin
                    entry_valid[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < exec_pkg::RS_DEPTH; i++) begin
            if (accept && alloc[i]) begin
                entry_op[i]    <= in_op;
                entry_rob[i]   <= in_rob;
                entry_src_a[i] <= in_src_a;
                entry_src_b[i] <= in_src_b;
            end
        end
    end

endmodule

//--- design/exec_if.sv
// ############################
// Issue and result interfaces
// Scheduler to unit issue, unit to arbiter result request
// ############################

`timescale 1ns/1ps

interface issue_if;

    logic                 valid;
    logic                 ready;
    exec_pkg::alu_op_t    op;
    exec_pkg::rob_tag_t   rob;
    exec_pkg::word_t      src_a;
    exec_pkg::word_t      src_b;

    modport sched (output valid, op, rob, src_a, src_b, input ready);
    modport unit  (input valid, op, rob, src_a, src_b, output ready);

endinterface

interface result_if;

    // rob and value stay stable while req waits for grant
    logic                 req;
    exec_pkg::rob_tag_t   rob;
    exec_pkg::word_t      value;
    logic                 grant;

    modport unit (output req, rob, value, input grant);
    modport arb  (input req, rob, value, output grant);

endinterface

//--- design/exec_pkg.sv
// ############################
// Execute stage shared types
// Data word, tag, operation and unit selection definitions
// ############################

package exec_pkg;

    // Data word carried on operands and results
    typedef logic [31:0] word_t;

    // Reorder-buffer tag of an in-flight instruction
    typedef logic [3:0] rob_tag_t;

    // Operations below MUL all execute on the integer ALUs
    typedef enum logic [3:0] {
        NOP   = 4'd0,
        ADD   = 4'd1,
        SUB   = 4'd2,
        AND   = 4'd3,
        OR    = 4'd4,
        XOR   = 4'd5,
        SLT   = 4'd6,
        SLL   = 4'd7,
        SRL   = 4'd8,
        SRA   = 4'd9,
        MUL   = 4'd10,
        MULHU = 4'd11,
        DIVU  = 4'd12,
        REMU  = 4'd13
    } alu_op_t;

    // One-hot unit select, bit 0 ALU0, bit 1 ALU1, bit 2 MUL, bit 3 DIV
    typedef logic [3:0] unit_sel_t;

    localparam int RS_DEPTH = 4;

    localparam int NUM_UNITS = 4;

    // One quotient bit is resolved per iteration
    localparam int DIV_STEPS = 32;

endpackage
